//--- Bender.yml
package:
  name: stat_counter

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/stat_pkg.sv
      - hw/priority_memory.sv
      - hw/stat_updater.sv
      - hw/host_reader.sv
      - hw/stat_counter_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clock.sv
      - testbench/tb_stat_counter.sv

//--- all.f
+incdir+include
hw/stat_pkg.sv
hw/priority_memory.sv
hw/stat_updater.sv
hw/host_reader.sv
hw/stat_counter_top.sv
testbench/tb_clock.sv
testbench/tb_stat_counter.sv

//--- hw/host_reader.sv
`timescale 1ns/10ps

module host_reader (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             host_rd,
	input  stat_pkg::index_t host_index,
	input  logic             event_accept,
	output logic             host_rden,
	output stat_pkg::index_t host_addr,
	input  stat_pkg::count_t rdata,
	output logic             host_rdata_valid,
	output stat_pkg::count_t host_rdata
);
	logic             pend;
	stat_pkg::index_t pend_idx;
	logic             issue;
	logic             rd_done;

	// Port B goes to the updater whenever an event is accepted, so the
	// pending read waits for a cycle without one. A new host_rd in the
	// same cycle takes over the slot and the old index is dropped.
	assign issue = pend & ~event_accept & ~host_rd;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pend <= 1'b0;
		else if (host_rd)
			pend <= 1'b1;
		else if (issue)
			pend <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (host_rd)
			pend_idx <= host_index; // replaces any older request.
	end

	assign host_rden = issue;
	assign host_addr = pend_idx;

	// data leaves the RAM one cycle after the read edge.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rd_done <= 1'b0;
		else
			rd_done <= issue;
	end

	assign host_rdata_valid = rd_done;
	assign host_rdata       = rdata; // only meaningful with the valid pulse.

endmodule

//--- hw/priority_memory.sv
`timescale 1ns/10ps

module priority_memory #(
	parameter type entry_t = logic [71:0],
	parameter int  ABITS   = 12
) (
	input  logic             clk,
	input  logic             wren_a,
	input  logic             rden_a,
	input  logic [ABITS-1:0] addr_a,
	input  entry_t           wdata_a,
	output entry_t           rdata_a,
	input  logic             wren_b,
	input  logic             rden_b,
	input  logic [ABITS-1:0] addr_b,
	input  entry_t           wdata_b,
	output entry_t           rdata_b
);
	localparam int DEPTH = 2**ABITS;

	entry_t mem [DEPTH];
	logic   a_hits_b;

	// port A writes the word port B looks at.
	assign a_hits_b = wren_a && (addr_a == addr_b);

	// read registers start cleared at power-up.
	initial begin
		rdata_a = '0;
		rdata_b = '0;
	end

	always @(posedge clk) begin
		// port A, write wins over read.
		if (wren_a)
			mem[addr_a] <= wdata_a;
		else if (rden_a)
			rdata_a <= mem[addr_a];

		// port B, write wins over read.
		if (wren_b) begin
			if (!a_hits_b) // port A keeps the word on a write collision.
				mem[addr_b] <= wdata_b;
		end else if (rden_b) begin
			if (a_hits_b)
				rdata_b <= wdata_a; // bypass of the word being written.
			else
				rdata_b <= mem[addr_b];
		end
	end

endmodule

//--- hw/stat_counter_top.sv
`timescale 1ns/10ps
`include "stat_settings.svh"

module stat_counter_top (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              event_valid,
	input  stat_pkg::index_t  event_index,
	input  stat_pkg::amount_t event_amount,
	input  logic              host_rd,
	input  stat_pkg::index_t  host_index,
	output logic              ready,
	output logic              host_rdata_valid,
	output stat_pkg::count_t  host_rdata
);
	logic             event_accept;
	logic             upd_rden;
	stat_pkg::index_t upd_addr;
	logic             host_rden;
	stat_pkg::index_t host_addr;
	logic             wren_a;
	stat_pkg::index_t addr_a;
	stat_pkg::count_t wdata_a;
	logic             rden_b;
	stat_pkg::index_t addr_b;
	stat_pkg::count_t rdata_b;

	// The host reader holds off while event_accept is high, so the two
	// port B readers never collide and the updater can win the select.
	assign rden_b = upd_rden | host_rden;
	assign addr_b = upd_rden ? upd_addr : host_addr;

	stat_updater u_updater (
		.clk          (clk),
		.arst_n       (arst_n),
		.event_valid  (event_valid),
		.event_index  (event_index),
		.event_amount (event_amount),
		.ready        (ready),
		.event_accept (event_accept),
		.upd_rden     (upd_rden),
		.upd_addr     (upd_addr),
		.rdata        (rdata_b),
		.wren_a       (wren_a),
		.addr_a       (addr_a),
		.wdata_a      (wdata_a)
	);

	host_reader u_host_reader (
		.clk              (clk),
		.arst_n           (arst_n),
		.host_rd          (host_rd),
		.host_index       (host_index),
		.event_accept     (event_accept),
		.host_rden        (host_rden),
		.host_addr        (host_addr),
		.rdata            (rdata_b),
		.host_rdata_valid (host_rdata_valid),
		.host_rdata       (host_rdata)
	);

	// port A only writes, port B only reads.
	priority_memory #(
		.entry_t (stat_pkg::count_t),
		.ABITS   (`STAT_ABITS)
	) u_mem (
		.clk     (clk),
		.wren_a  (wren_a),
		.rden_a  (1'b0),
		.addr_a  (addr_a),
		.wdata_a (wdata_a),
		.rdata_a (),
		.wren_b  (1'b0),
		.rden_b  (rden_b),
		.addr_b  (addr_b),
		.wdata_b ('0),
		.rdata_b (rdata_b)
	);

endmodule

//--- hw/stat_pkg.sv
`include "stat_settings.svh"

package stat_pkg;

	// Types shared by the updater, the host reader and the top.
	// The table RAM is generic and takes count_t as its payload type.

	// table index, selects one counter.
	typedef logic [`STAT_ABITS-1:0] index_t;

	// one counter, also the width of a RAM word.
	typedef logic [`STAT_COUNT_W-1:0] count_t;

	// increment carried by one event.
	typedef logic [`STAT_AMOUNT_W-1:0] amount_t;

	// An event adds amount_t to count_t. The sum is formed one bit wider
	// than count_t, so the carry out marks the saturation case.

endpackage

//--- hw/stat_updater.sv
`timescale 1ns/10ps

module stat_updater (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              event_valid,
	input  stat_pkg::index_t  event_index,
	input  stat_pkg::amount_t event_amount,
	output logic              ready,
	output logic              event_accept,
	output logic              upd_rden,
	output stat_pkg::index_t  upd_addr,
	input  stat_pkg::count_t  rdata,
	output logic              wren_a,
	output stat_pkg::index_t  addr_a,
	output stat_pkg::count_t  wdata_a
);
	localparam int COUNT_W = $bits(stat_pkg::count_t);

	logic              sweep;
	stat_pkg::index_t  clr_idx;
	logic              s1_valid;
	stat_pkg::index_t  s1_index;
	stat_pkg::amount_t s1_amount;
	logic [COUNT_W:0]  sum_wide;
	stat_pkg::count_t  sum_sat;

	// Clear sweep. The table has no reset of its own, so the first cycle
	// after reset starts a pass that writes zero to every index. ready
	// rises together with the last write and stays high from then on.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sweep   <= 1'b0;
			ready   <= 1'b0;
			clr_idx <= '0;
		end else if (sweep) begin
			clr_idx <= clr_idx + 1'b1;
			if (&clr_idx) begin // last index written this cycle.
				sweep <= 1'b0;
				ready <= 1'b1;
			end
		end else if (!ready) begin
			sweep <= 1'b1;
		end
	end

	// events before ready are dropped.
	assign event_accept = event_valid & ready;

	// stage 0, the counter is read on port B at the accept edge.
	assign upd_rden = event_accept;
	assign upd_addr = event_index;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= event_accept;
	end

	always_ff @(posedge clk) begin
		if (event_accept) begin
			s1_index  <= event_index;
			s1_amount <= event_amount;
		end
	end

	// Stage 1. rdata holds the counter read at the accept edge. If the
	// previous event hit the same index, the RAM bypass has already put
	// that event's sum here, so no forwarding is needed in this block.
	always_comb begin
		sum_wide = {1'b0, rdata} + s1_amount;
		if (sum_wide[COUNT_W])
			sum_sat = '1; // carry out, hold at the largest count.
		else
			sum_sat = sum_wide[COUNT_W-1:0];
	end

	// Port A belongs to this block. The sweep and stage 1 never overlap,
	// since stage 1 only fills once ready is high.
	always_comb begin
		wren_a = sweep | s1_valid;
		if (sweep) begin
			addr_a  = clr_idx;
			wdata_a = '0;
		end else begin
			addr_a  = s1_index;
			wdata_a = sum_sat;
		end
	end

endmodule

//--- include/stat_settings.svh
`ifndef STAT_SETTINGS_SVH
`define STAT_SETTINGS_SVH

// index bits, 64 counters.
`define STAT_ABITS 6

// bits per counter.
`define STAT_COUNT_W 16

// bits per event increment. no wider than a counter.
`define STAT_AMOUNT_W 8

`endif

//--- testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic arst_n
);
	localparam int RESET_CYCLES = 8;

	initial begin
		clk    = 1'b0;
		arst_n = 1'b0;
	end

	always #2 clk = ~clk; // 4 ns period.

	initial begin
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

//--- testbench/tb_stat_counter.sv
`timescale 1ns/10ps
`include "stat_settings.svh"

module tb_stat_counter;
	localparam int DEPTH         = 2**`STAT_ABITS;
	localparam int SEED          = 5245;
	localparam int RESET_TIMEOUT = 50;
	localparam int READY_TIMEOUT = 200;
	localparam int READ_TIMEOUT  = 64;
	localparam int RANDOM_CYCLES = 400;
	localparam int AMOUNT_MAX    = 2**`STAT_AMOUNT_W - 1;
	localparam stat_pkg::count_t MAX_COUNT = '1;

	logic              clk;
	logic              arst_n;
	logic              event_valid;
	stat_pkg::index_t  event_index;
	stat_pkg::amount_t event_amount;
	logic              host_rd;
	stat_pkg::index_t  host_index;
	logic              ready;
	logic              host_rdata_valid;
	stat_pkg::count_t  host_rdata;

	stat_pkg::count_t model [DEPTH]; // expected counter values.
	int               error_count;
	int               check_count;

	tb_clock u_clock (
		.clk    (clk),
		.arst_n (arst_n)
	);

	stat_counter_top u_dut (
		.clk              (clk),
		.arst_n           (arst_n),
		.event_valid      (event_valid),
		.event_index      (event_index),
		.event_amount     (event_amount),
		.host_rd          (host_rd),
		.host_index       (host_index),
		.ready            (ready),
		.host_rdata_valid (host_rdata_valid),
		.host_rdata       (host_rdata)
	);

	function automatic stat_pkg::count_t add_saturate(input stat_pkg::count_t count,
							  input stat_pkg::amount_t amount);
		int unsigned total;
		total = int'(count) + int'(amount);
		if (total > int'(MAX_COUNT))
			return MAX_COUNT;
		return stat_pkg::count_t'(total);
	endfunction

	task automatic check_value(input string what, input int idx,
				   input stat_pkg::count_t got, input stat_pkg::count_t expected);
		check_count++;
		assert (got == expected) else begin
			$display("MISMATCH at %0t: %s, index %0d read %0d, expected %0d",
				 $time, what, idx, got, expected);
			error_count++;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		if (error_count == errors_before)
			$display("%s: pass", name);
		else
			$display("%s: fail, %0d errors", name, error_count - errors_before);
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (!arst_n && waited < RESET_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		assert (arst_n) else begin
			$display("reset was still asserted after %0d cycles", RESET_TIMEOUT);
			error_count++;
		end
	endtask

	task automatic wait_ready();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!ready && waited < READY_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		assert (ready) else begin
			$display("ready did not rise within %0d cycles after reset", READY_TIMEOUT);
			error_count++;
		end
	endtask

	// one event, the model follows it.
	task automatic send_event(input stat_pkg::index_t idx, input stat_pkg::amount_t amount);
		@(posedge clk);
		event_valid  <= 1'b1;
		event_index  <= idx;
		event_amount <= amount;
		model[idx] = add_saturate(model[idx], amount);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			event_valid <= 1'b0;
			host_rd     <= 1'b0;
		end
	endtask

	task automatic read_and_check(input stat_pkg::index_t idx, input string what);
		int               waited;
		bit               seen;
		stat_pkg::count_t expected;
		expected = model[idx];
		@(posedge clk);
		event_valid <= 1'b0;
		host_rd     <= 1'b1;
		host_index  <= idx;
		@(posedge clk);
		host_rd <= 1'b0;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < READ_TIMEOUT) begin
			@(negedge clk);
			if (host_rdata_valid)
				seen = 1'b1;
			else
				waited++;
		end
		assert (seen) else begin
			$display("host read of index %0d returned no data within %0d cycles",
				 idx, READ_TIMEOUT);
			error_count++;
		end
		if (seen)
			check_value(what, idx, host_rdata, expected);
	endtask

	// Events during the clear sweep must be dropped, so the model is left alone.
	task automatic test_events_before_ready();
		int               mark;
		stat_pkg::index_t hit [$];
		stat_pkg::index_t idx;
		mark = error_count;
		wait_reset_release();
		repeat (20) begin
			@(negedge clk);
			check_count++;
			assert (!ready) else begin
				$display("ready was high before the clear sweep could have ended");
				error_count++;
			end
			@(posedge clk);
			idx = stat_pkg::index_t'($urandom_range(DEPTH - 1));
			hit.push_back(idx);
			event_valid  <= 1'b1;
			event_index  <= idx;
			event_amount <= stat_pkg::amount_t'($urandom_range(1, AMOUNT_MAX));
		end
		idle(1);
		wait_ready();
		foreach (hit[i])
			read_and_check(hit[i], "event before ready");
		end_test("events before ready", mark);
	endtask

	task automatic test_clear_after_reset();
		int mark;
		mark = error_count;
		wait_ready();
		read_and_check(0, "cleared entry");
		read_and_check(1, "cleared entry");
		read_and_check(17, "cleared entry");
		read_and_check(42, "cleared entry");
		read_and_check(DEPTH - 1, "cleared entry");
		end_test("clear after reset", mark);
	endtask

	task automatic test_distinct_indices();
		int mark;
		mark = error_count;
		send_event(3, 5);
		idle(2);
		send_event(10, 100);
		idle(1);
		send_event(3, 7);
		send_event(20, 255);
		idle(3);
		send_event(45, 1);
		send_event(10, 33);
		idle(2);
		read_and_check(3, "distinct indices");
		read_and_check(10, "distinct indices");
		read_and_check(20, "distinct indices");
		read_and_check(45, "distinct indices");
		end_test("distinct indices", mark);
	endtask

	// consecutive events to one index rely on the RAM bypass.
	task automatic test_back_to_back();
		int mark;
		mark = error_count;
		send_event(12, 17);
		send_event(12, 200);
		send_event(12, 3);
		send_event(12, 99);
		send_event(12, 255);
		send_event(13, 255);
		send_event(12, 1);
		send_event(13, 255);
		idle(2);
		read_and_check(12, "back to back");
		read_and_check(13, "back to back");
		end_test("back to back", mark);
	endtask

	task automatic test_random_stream();
		int                mark;
		int                cycle;
		int                last_event [DEPTH];
		bit                pending;
		stat_pkg::index_t  pend_idx;
		stat_pkg::count_t  pend_exp;
		int                pend_age;
		stat_pkg::index_t  ev_idx;
		stat_pkg::index_t  rd_idx;
		stat_pkg::amount_t amount;
		mark    = error_count;
		pending = 1'b0;
		foreach (last_event[i])
			last_event[i] = -10;
		for (cycle = 0; cycle < RANDOM_CYCLES || pending; cycle++) begin
			@(posedge clk);
			event_valid <= 1'b0;
			host_rd     <= 1'b0;
			if (!pending && cycle < RANDOM_CYCLES && $urandom_range(3) == 0) begin
				rd_idx = stat_pkg::index_t'($urandom_range(DEPTH - 1));
				if (cycle - last_event[rd_idx] >= 2) begin
					host_rd    <= 1'b1;
					host_index <= rd_idx;
					pending  = 1'b1;
					pend_idx = rd_idx;
					pend_exp = model[rd_idx]; // value before any later event.
					pend_age = 0;
				end
			end
			if (cycle < RANDOM_CYCLES && $urandom_range(9) < 7) begin
				ev_idx = stat_pkg::index_t'($urandom_range(DEPTH - 1));
				if (pending && ev_idx == pend_idx)
					ev_idx = ev_idx + 1'b1; // keep the pending read stable.
				amount = stat_pkg::amount_t'($urandom_range(AMOUNT_MAX));
				event_valid  <= 1'b1;
				event_index  <= ev_idx;
				event_amount <= amount;
				model[ev_idx] = add_saturate(model[ev_idx], amount);
				last_event[ev_idx] = cycle;
			end
			@(negedge clk);
			if (pending) begin
				if (host_rdata_valid) begin
					check_value("random stream", pend_idx, host_rdata, pend_exp);
					pending = 1'b0;
				end else begin
					pend_age++;
					assert (pend_age <= READ_TIMEOUT) else begin
						$display("host read of index %0d stalled past %0d cycles",
							 pend_idx, READ_TIMEOUT);
						error_count++;
						pending = 1'b0;
					end
				end
			end
		end
		idle(2);
		end_test("random stream", mark);
	endtask

	task automatic test_saturation();
		int mark;
		mark = error_count;
		repeat (300)
			send_event(7, 255);
		idle(2);
		read_and_check(7, "saturation");
		end_test("saturation", mark);
	endtask

	initial begin
		void'($urandom(SEED));
		error_count  = 0;
		check_count  = 0;
		event_valid  = 1'b0;
		event_index  = '0;
		event_amount = '0;
		host_rd      = 1'b0;
		host_index   = '0;
		foreach (model[i])
			model[i] = '0; // the sweep clears the whole table.

		test_events_before_ready();
		test_clear_after_reset();
		test_distinct_indices();
		test_back_to_back();
		test_random_stream();
		test_saturation();

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
